// File: mandel.f
design/mandel_pkg.sv
design/seq_mult_signed.sv
design/escape_core.sv
design/pixel_scan.sv
design/result_collect.sv
design/mandel_top.sv
dv/mandel_asserts.sv
dv/mandel_tb.sv

// File: dv/mandel_tb.sv
`default_nettype none

module mandel_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import mandel_pkg::*;

   localparam int NUM_FRAMES  = 15;   // directed, random and reset frames
   localparam int PIX_CYCLES  = MAX_ITERS * (3 * (DATA_W + 2) + 2);
   localparam int CYCLE_LIMIT = NUM_FRAMES * TILE_W * TILE_H * PIX_CYCLES + 5000;
   localparam int TILE_PIX    = TILE_W * TILE_H;

   logic             i_clk;
   logic             i_nrst;
   logic             i_start;
   frame_req_t       i_req;
   logic             o_pix_valid;
   pix_res_t         o_pix;
   logic [CNT_W-1:0] o_inset_count;
   logic             o_frame_done;
   logic             o_busy;

   logic [31:0]      lfsr;
   frame_req_t       cur_req;   // frame the compare process predicts
   pix_res_t         exp_pix;
   int               rec_idx     = 0;
   int               inset_exp   = 0;
   int               frames_done = 0;
   int               cycles      = 0;

   mandel_top UUT (
      .i_clk         (i_clk),
      .i_nrst        (i_nrst),
      .i_start       (i_start),
      .i_req         (i_req),
      .o_pix_valid   (o_pix_valid),
      .o_pix         (o_pix),
      .o_inset_count (o_inset_count),
      .o_frame_done  (o_frame_done),
      .o_busy        (o_busy)
   );

   initial begin
      i_clk = 1'b0;
      forever #10 i_clk = ~i_clk;
   end

   // galois form with taps 32 22 2 1
   function automatic logic lfsr_step();
      logic out_bit;
      out_bit = lfsr[0];
      lfsr    = lfsr >> 1;
      if (out_bit) begin
         lfsr = lfsr ^ 32'h8020_0003;
      end
      return out_bit;
   endfunction

   function automatic int rand_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         v = (v << 1) | int'(lfsr_step());
      end
      return v;
   endfunction

   function automatic frame_req_t make_req(input int ore, input int oim, input int sre,
                                           input int sim);
      frame_req_t req;
      req.origin.re = DATA_W'(ore);
      req.origin.im = DATA_W'(oim);
      req.step.re   = DATA_W'(sre);
      req.step.im   = DATA_W'(sim);
      return req;
   endfunction

   function automatic frame_req_t random_req();
      int ore;
      int oim;
      int sre;
      int sim;
      ore = -10240 + rand_bits(13);   // -2.5 .. -0.5
      oim = -6144 + rand_bits(13);    // -1.5 .. 0.5
      sre = 16 + rand_bits(9);
      sim = 16 + rand_bits(9);
      return make_req(ore, oim, sre, sim);
   endfunction

   // c of pixel (x,y) wrapping like the repeated step adds
   function automatic cplx_t point_c(input frame_req_t req, input int x, input int y);
      cplx_t c;
      c.re = DATA_W'(int'(req.origin.re) + x * int'(req.step.re));
      c.im = DATA_W'(int'(req.origin.im) + y * int'(req.step.im));
      return c;
   endfunction

   function automatic pix_res_t ref_point(input cplx_t c, input int x, input int y);
      pix_res_t                 res;
      int                       re;
      int                       im;
      int                       rr;
      int                       ii;
      int                       ri;
      int                       cnt;
      logic                     escaped;
      logic signed [DATA_W-1:0] nre;
      logic signed [DATA_W-1:0] nim;
      re      = int'(c.re);
      im      = int'(c.im);
      cnt     = 0;
      escaped = 1'b0;
      while (cnt < MAX_ITERS - 1 && !escaped) begin
         rr = (re * re) >>> FRAC_W;
         ii = (im * im) >>> FRAC_W;
         ri = (re * im) >>> FRAC_W;
         if (rr + ii > ESCAPE_LIM) begin
            escaped = 1'b1;
         end else begin
            nre = DATA_W'(rr - ii + int'(c.re));
            nim = DATA_W'(2 * ri + int'(c.im));
            re  = int'(nre);
            im  = int'(nim);
            cnt++;
         end
      end
      res.x       = PIX_W'(x);
      res.y       = PIX_W'(y);
      res.iter    = ITER_W'(cnt);
      res.bounded = ~escaped;
      return res;
   endfunction

   task automatic report_failure(input string why);
      $display("%s", why);
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic check_pix(input pix_res_t exp, input pix_res_t got);
      if (got !== exp) begin
         report_failure($sformatf("error o_pix: expected %h got %h", exp, got));
      end
   endtask

   task automatic check_count(input logic [CNT_W-1:0] exp, input logic [CNT_W-1:0] got);
      if (got !== exp) begin
         report_failure($sformatf("error o_inset_count: expected %h got %h", exp, got));
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         report_failure($sformatf("error %s: expected %h got %h", name, exp, got));
      end
   endtask

   task automatic start_frame(input frame_req_t req);
      while (o_busy) @(negedge i_clk);
      cur_req = req;
      i_req   = req;
      i_start = 1'b1;
      @(negedge i_clk);
      i_start = 1'b0;
   endtask

   task automatic run_frame(input frame_req_t req);
      int target;
      target = frames_done + 1;
      start_frame(req);
      while (frames_done < target) @(negedge i_clk);
   endtask

   // predicts raster order and compares every record
   always @(posedge i_clk) begin
      if (!i_nrst) begin
         rec_idx   = 0;
         inset_exp = 0;
      end else begin
         if (o_pix_valid) begin
            if (rec_idx >= TILE_PIX) begin
               report_failure("more pixel records than the tile holds in one frame");
            end
            exp_pix = ref_point(point_c(cur_req, rec_idx % TILE_W, rec_idx / TILE_W),
                                rec_idx % TILE_W, rec_idx / TILE_W);
            check_pix(exp_pix, o_pix);
            if (exp_pix.bounded) begin
               inset_exp++;
            end
            rec_idx++;
         end
         if (o_frame_done) begin
            if (rec_idx != TILE_PIX) begin
               report_failure($sformatf("frame ended after %0d pixel records", rec_idx));
            end
            check_count(CNT_W'(inset_exp), o_inset_count);
            frames_done++;
            rec_idx   = 0;
            inset_exp = 0;
         end
      end
   end

   always @(posedge i_clk) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         report_failure("timeout, the frames did not finish within the cycle limit");
      end
      if (UUT.u_asserts.fail_count != 0) begin
         report_failure("a concurrent assertion on the design failed");
      end
   end

   initial begin
      i_nrst  = 1'b0;
      i_start = 1'b0;
      i_req   = '0;
      cur_req = '0;
      lfsr    = 32'heb24c447;
      repeat (3) @(negedge i_clk);
      i_nrst = 1'b1;

      run_frame(make_req(-164, -164, 41, 41));   // around 0 and all in the set
      check_count(CNT_W'(TILE_PIX), o_inset_count);
      run_frame(make_req(-16380, 8192, 1024, 1024));   // far outside
      check_count('0, o_inset_count);
      run_frame(make_req(-8192, -4096, 1434, 1147));   // across the boundary

      for (int i = 0; i < 10; i++) begin
         run_frame(random_req());
      end

      // reset in the middle of a frame
      start_frame(make_req(-8192, -4096, 1434, 1147));
      while (rec_idx < 10) @(negedge i_clk);
      i_nrst = 1'b0;
      @(negedge i_clk);
      check_flag("o_busy", 1'b0, o_busy);
      check_flag("o_pix_valid", 1'b0, o_pix_valid);
      check_flag("o_frame_done", 1'b0, o_frame_done);
      repeat (2) @(negedge i_clk);
      i_nrst = 1'b1;
      @(negedge i_clk);
      check_flag("o_busy", 1'b0, o_busy);
      check_flag("o_pix_valid", 1'b0, o_pix_valid);
      check_flag("o_frame_done", 1'b0, o_frame_done);
      run_frame(random_req());

      if (UUT.u_asserts.fail_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: dv/mandel_asserts.sv
`default_nettype none

module mandel_asserts (
   input wire                           i_clk,
   input wire                           i_nrst,
   input wire                           i_core_done,
   input wire                           i_last,
   input wire                           i_pix_valid,
   input wire  mandel_pkg::pix_res_t    i_pix,
   input wire  [mandel_pkg::CNT_W-1:0]  i_inset_count,
   input wire                           i_frame_done,
   input wire                           i_busy
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_count = 0;   // read by the testbench

   // a high done also restarts the core
   a_done_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_core_done |=> !i_core_done)
      else begin
         $error("escape core done stayed high for more than one cycle");
         fail_count++;
      end

   a_pix_in_frame: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (i_pix_valid && !i_busy) |-> $past(i_core_done && i_last))
      else begin
         $error("pixel record outside a frame");
         fail_count++;
      end

   a_done_apart: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !(i_frame_done && i_pix_valid))
      else begin
         $error("frame done together with a pixel record");
         fail_count++;
      end

   a_known: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !$isunknown({i_pix_valid, i_pix, i_inset_count, i_frame_done, i_busy}))
      else begin
         $error("unknown value on a top level output");
         fail_count++;
      end

endmodule

bind mandel_top mandel_asserts u_asserts (
   .i_clk         (i_clk),
   .i_nrst        (i_nrst),
   .i_core_done   (core_done),
   .i_last        (last),
   .i_pix_valid   (o_pix_valid),
   .i_pix         (o_pix),
   .i_inset_count (o_inset_count),
   .i_frame_done  (o_frame_done),
   .i_busy        (o_busy)
);

`default_nettype wire

// File: design/mandel_top.sv
`default_nettype none

module mandel_top (
   input  wire                           i_clk,
   input  wire                           i_nrst,
   input  wire                           i_start,
   input  wire  mandel_pkg::frame_req_t  i_req,
   output logic                          o_pix_valid,
   output mandel_pkg::pix_res_t          o_pix,
   output logic [mandel_pkg::CNT_W-1:0]  o_inset_count,
   output logic                          o_frame_done,
   output logic                          o_busy
);
   import mandel_pkg::*;

   point_t            point;
   logic              point_valid;
   logic              last;
   logic              core_done;
   logic              core_bounded;
   logic [ITER_W-1:0] core_iter;

   pixel_scan u_scan (
      .i_clk         (i_clk),
      .i_nrst        (i_nrst),
      .i_start       (i_start),
      .i_req         (i_req),
      .i_done        (core_done),
      .o_point_valid (point_valid),
      .o_point       (point),
      .o_last        (last),
      .o_busy        (o_busy)
   );

   escape_core u_core (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_valid   (point_valid),
      .i_c       (point.c),
      .o_iter    (core_iter),
      .o_bounded (core_bounded),
      .o_done    (core_done)
   );

   result_collect u_collect (
      .i_clk         (i_clk),
      .i_nrst        (i_nrst),
      .i_start       (i_start),
      .i_done        (core_done),
      .i_iter        (core_iter),
      .i_bounded     (core_bounded),
      .i_point       (point),
      .i_last        (last),
      .o_pix_valid   (o_pix_valid),
      .o_pix         (o_pix),
      .o_inset_count (o_inset_count),
      .o_frame_done  (o_frame_done)
   );

endmodule

`default_nettype wire

// File: design/result_collect.sv
`default_nettype none

module result_collect (
   input  wire                           i_clk,
   input  wire                           i_nrst,
   input  wire                           i_start,
   input  wire                           i_done,
   input  wire  [mandel_pkg::ITER_W-1:0] i_iter,
   input  wire                           i_bounded,
   input  wire  mandel_pkg::point_t      i_point,
   input  wire                           i_last,
   output logic                          o_pix_valid,
   output mandel_pkg::pix_res_t          o_pix,
   output logic [mandel_pkg::CNT_W-1:0]  o_inset_count,
   output logic                          o_frame_done
);
   import mandel_pkg::*;

   logic [CNT_W-1:0] run_count;   // bounded pixels so far in this frame
   logic             last_q;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_pix_valid   <= 1'b0;
         o_pix         <= '0;
         last_q        <= 1'b0;
         o_frame_done  <= 1'b0;
         run_count     <= '0;
         o_inset_count <= '0;
      end else begin
         o_pix_valid  <= i_done;
         last_q       <= i_done & i_last;
         o_frame_done <= last_q;   // one cycle behind the last record
         if (i_done) begin
            o_pix <= '{x: i_point.x, y: i_point.y, iter: i_iter, bounded: i_bounded};
         end
         if (i_start) begin
            run_count <= '0;
         end else if (i_done && i_bounded) begin
            run_count <= run_count + 1'b1;
         end
         // snapshot so a quick restart cannot clear the reported count
         if (last_q) begin
            o_inset_count <= run_count;
         end
      end
   end

endmodule

`default_nettype wire

// File: design/pixel_scan.sv
`default_nettype none

module pixel_scan (
   input  wire                        i_clk,
   input  wire                        i_nrst,
   input  wire                        i_start,
   input  wire  mandel_pkg::frame_req_t i_req,
   input  wire                        i_done,
   output logic                       o_point_valid,
   output mandel_pkg::point_t         o_point,
   output logic                       o_last,
   output logic                       o_busy
);
   import mandel_pkg::*;

   frame_req_t       req_q;
   cplx_t            c;   // c.im doubles as the row-start im
   logic [PIX_W-1:0] x;
   logic [PIX_W-1:0] y;
   logic             valid;
   logic             busy;
   logic             row_end;
   logic             start_ok;

   assign start_ok      = i_start & ~busy;
   assign row_end       = (x == PIX_W'(TILE_W - 1));
   assign o_last        = row_end & (y == PIX_W'(TILE_H - 1));
   assign o_point_valid = valid;
   assign o_busy        = busy;
   assign o_point       = '{c: c, x: x, y: y};

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy  <= 1'b0;
         valid <= 1'b0;
         x     <= '0;
         y     <= '0;
      end else if (start_ok) begin
         busy  <= 1'b1;
         valid <= 1'b1;
         x     <= '0;
         y     <= '0;
      end else if (i_done) begin
         valid <= 1'b0;   // one idle cycle between points
         if (o_last) begin
            busy <= 1'b0;
         end
         if (row_end) begin
            x <= '0;
            y <= (y == PIX_W'(TILE_H - 1)) ? '0 : y + 1'b1;
         end else begin
            x <= x + 1'b1;
         end
      end else if (busy && !valid) begin
         valid <= 1'b1;
      end
   end

   always_ff @(posedge i_clk) begin
      if (start_ok) begin
         req_q <= i_req;
         c     <= i_req.origin;
      end else if (i_done) begin
         if (row_end) begin
            c.re <= req_q.origin.re;
            c.im <= c.im + req_q.step.im;
         end else begin
            c.re <= c.re + req_q.step.re;
         end
      end
   end

endmodule

`default_nettype wire

// File: design/escape_core.sv
`default_nettype none

module escape_core (
   input  wire                              i_clk,
   input  wire                              i_nrst,
   input  wire                              i_valid,
   input  wire  mandel_pkg::cplx_t          i_c,
   output logic [mandel_pkg::ITER_W-1:0]    o_iter,
   output logic                             o_bounded,
   output logic                             o_done
);
   import mandel_pkg::*;

   logic [1:0]               state;
   logic [1:0]               state_next;
   logic                     reset_run;
   logic                     load_c;
   logic                     chk;
   logic                     esc_hit;

   logic signed [DATA_W-1:0] re;
   logic signed [DATA_W-1:0] im;
   logic signed [DATA_W-1:0] mul_a;
   logic signed [DATA_W-1:0] mul_b;
   logic                     mul_valid;
   logic                     mul_acc;

   logic signed [PROD_W-1:0] mul_c;
   logic signed [PROD_W-1:0] prod_sh;
   logic signed [PROD_W-1:0] re_sq;
   logic signed [PROD_W-1:0] im_sq;
   logic signed [PROD_W-1:0] re_im;
   logic signed [PROD_W-1:0] mag;
   logic signed [PROD_W-1:0] re_calc;
   logic signed [PROD_W-1:0] im_calc;

   assign reset_run = o_done | ~i_valid;
   assign load_c    = reset_run | ((state == ST_IDLE) & ~chk);   // z = c at run start

   assign prod_sh   = mul_c >>> FRAC_W;
   assign mag       = re_sq + im_sq;
   assign esc_hit   = chk & (mag > ESCAPE_LIM);   // chk marks fresh squares of z

   assign re_calc   = re_sq - im_sq + $signed(i_c.re);
   assign im_calc   = (re_im <<< 1) + $signed(i_c.im);

   assign o_done    = i_valid & (esc_hit | (o_iter == ITER_W'(MAX_ITERS - 1)));
   assign o_bounded = ~esc_hit;

   // operand select per pass
   assign mul_valid = (state != ST_IDLE);
   assign mul_a     = ((state == ST_RE_RE) || (state == ST_RE_IM)) ? re : im;
   assign mul_b     = (state == ST_RE_RE) ? re : im;

   always_comb begin
      state_next = state;
      if (reset_run) begin
         state_next = ST_IDLE;
      end else begin
         case (state)
            ST_IDLE:  state_next = ST_RE_RE;
            ST_RE_RE: if (mul_acc) state_next = ST_RE_IM;
            ST_RE_IM: if (mul_acc) state_next = ST_IM_IM;
            default:  if (mul_acc) state_next = ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state  <= ST_IDLE;
         chk    <= 1'b0;
         o_iter <= '0;
      end else begin
         state <= state_next;
         chk   <= ~reset_run & (state == ST_IM_IM) & mul_acc;
         if (reset_run) begin
            o_iter <= '0;
         end else if (chk) begin
            o_iter <= o_iter + 1'b1;   // no escape, one more iteration
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (load_c) begin
         re <= i_c.re;
         im <= i_c.im;
      end else if (chk) begin
         re <= re_calc[DATA_W-1:0];   // truncate back to Q4.12
         im <= im_calc[DATA_W-1:0];
      end
      if (mul_acc) begin
         case (state)
            ST_RE_RE: re_sq <= prod_sh;
            ST_RE_IM: re_im <= prod_sh;
            ST_IM_IM: im_sq <= prod_sh;
            default:  ;
         endcase
      end
   end

   seq_mult_signed u_mult (
      .i_clk    (i_clk),
      .i_nrst   (i_nrst),
      .i_valid  (mul_valid),
      .i_a      (mul_a),
      .i_b      (mul_b),
      .o_c      (mul_c),
      .o_accept (mul_acc)
   );

endmodule

`default_nettype wire

// File: design/seq_mult_signed.sv
`default_nettype none

module seq_mult_signed (
   input  wire                                   i_clk,
   input  wire                                   i_nrst,
   input  wire                                   i_valid,
   input  wire  signed [mandel_pkg::DATA_W-1:0]  i_a,
   input  wire  signed [mandel_pkg::DATA_W-1:0]  i_b,
   output logic signed [mandel_pkg::PROD_W-1:0]  o_c,
   output logic                                  o_accept
);
   import mandel_pkg::*;

   logic                 busy;
   logic [MUL_CNT_W-1:0] cnt;
   logic                 last_step;
   logic                 neg;
   logic [DATA_W-1:0]    mag_a;
   logic [DATA_W-1:0]    mag_b;
   logic [PROD_W-1:0]    mcand;
   logic [DATA_W-1:0]    mplier;
   logic [PROD_W-1:0]    acc;

   // magnitudes, -2^15 maps to 2^15 which still fits unsigned
   assign mag_a = i_a[DATA_W-1] ? DATA_W'(-i_a) : DATA_W'(i_a);
   assign mag_b = i_b[DATA_W-1] ? DATA_W'(-i_b) : DATA_W'(i_b);

   assign last_step = busy && (cnt == MUL_CNT_W'(DATA_W));
   assign o_accept  = last_step;
   assign o_c       = neg ? -$signed(acc) : $signed(acc);   // restore sign

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy <= 1'b0;
         cnt  <= '0;
      end else if (!i_valid) begin
         busy <= 1'b0;   // abort on dropped valid
      end else if (!busy) begin
         busy <= 1'b1;
         cnt  <= '0;
      end else if (last_step) begin
         busy <= 1'b0;   // next product loads on the following cycle
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_valid && !busy) begin
         mcand  <= PROD_W'(mag_a);
         mplier <= mag_b;
         acc    <= '0;
         neg    <= i_a[DATA_W-1] ^ i_b[DATA_W-1];
      end else if (busy && !last_step) begin
         if (mplier[0]) begin
            acc <= acc + mcand;
         end
         mcand  <= mcand << 1;
         mplier <= mplier >> 1;
      end
   end

endmodule

`default_nettype wire

// File: design/mandel_pkg.sv
`default_nettype none

package mandel_pkg;

   // signed Q4.12 fixed point
   localparam int DATA_W     = 16;
   localparam int FRAC_W     = 12;
   localparam int PROD_W     = 2 * DATA_W;
   localparam int ESCAPE_LIM = 2 ** (DATA_W - 2);   // 4.0 once the product is shifted

   localparam int MAX_ITERS  = 64;
   localparam int ITER_W     = $clog2(MAX_ITERS);

   localparam int TILE_W     = 8;
   localparam int TILE_H     = 8;
   localparam int PIX_W      = 3;
   localparam int CNT_W      = $clog2(TILE_W * TILE_H + 1);   // in-set pixel count

   localparam int MUL_CNT_W  = $clog2(DATA_W + 1);   // shift-add step counter

   // escape core states
   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_RE_RE = 2'd1;
   localparam logic [1:0] ST_RE_IM = 2'd2;
   localparam logic [1:0] ST_IM_IM = 2'd3;

   typedef struct packed {
      logic signed [DATA_W-1:0] re;
      logic signed [DATA_W-1:0] im;
   } cplx_t;

   typedef struct packed {
      cplx_t origin;   // point of pixel (0,0)
      cplx_t step;     // re per column, im per row
   } frame_req_t;

   typedef struct packed {
      cplx_t            c;
      logic [PIX_W-1:0] x;
      logic [PIX_W-1:0] y;
   } point_t;

   typedef struct packed {
      logic [PIX_W-1:0]  x;
      logic [PIX_W-1:0]  y;
      logic [ITER_W-1:0] iter;
      logic              bounded;
   } pix_res_t;

endpackage

`default_nettype wire
